/* vlog.f */
common/du_cmd_pkg.sv
common/du_cpu_pkg.sv
rtl/du_byte_fifo.sv
debug_unit/du_master.sv
debug_unit/du_imem_loader.sv
debug_unit/du_regfile_tx.sv
debug_unit/debug_unit_top.sv
rtl/du_subsystem_top.sv
verif/tb_du_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_du_subsystem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_du_subsystem.sv */
`timescale 1ns/1ns
// Testbench for the debug subsystem
// UART and CPU models, command stimulus, checking assertions
module tb_du_subsystem;
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    logic                       clk;
    logic                       i_rst;
    logic [NB_UART_DATA-1:0]    i_rx_data;
    logic                       i_rx_done;
    logic                       o_rx_full;
    logic                       o_tx_start;
    logic [NB_UART_DATA-1:0]    o_tx_data;
    logic                       i_tx_done;
    logic                       o_cpu_en;
    logic [NB_PC-1:0]           i_pc;
    logic                       o_regfile_rd;
    logic [NB_REGFILE_ADDR-1:0] o_regfile_raddr;
    logic [NB_REG-1:0]          i_regfile_data;
    logic [NB_INSTRUCTION-1:0]  o_imem_data;
    logic [IMEM_ADDR_WIDTH-1:0] o_imem_waddr;
    logic [NB_WSIZE-1:0]        o_imem_wsize;
    logic                       o_imem_wen;

    logic [31:0]             lfsr = 32'h6ce3_6ba2;
    logic [NB_UART_DATA-1:0] tx_log [$];           // Bytes seen on the UART
    logic [NB_UART_DATA-1:0] exp_bytes [1024];
    int                      exp_wr = 0;
    int                      exp_rd = 0;
    logic [31:0]             exp_word [2**IMEM_ADDR_WIDTH];
    int                      n_words = 0;
    int                      imem_wr_cnt = 0;      // IMEM writes seen so far
    logic                    init_done = 1'b0;
    logic                    started = 1'b0;
    logic                    run_mode = 1'b0;
    logic                    prev_en = 1'b0;
    logic                    halt_pop;

    assign halt_pop = i_du_subsystem_top.rx_rd && (i_du_subsystem_top.rx_head == CMD_HALT);

    du_subsystem_top i_du_subsystem_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic push_byte(input logic [7:0] b);
        exp_bytes[exp_wr] = b;
        exp_wr++;
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) push_byte(w[8*i +: 8]);  // LSB first
    endtask

    task automatic send_byte(input logic [7:0] b);
        int t;
        t = 0;
        while (o_rx_full) begin
            @(negedge clk);
            t++;
            if (t > 2000) fail_timeout("room in the receive FIFO");
        end
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(negedge clk);
        i_rx_done = 1'b0;
    endtask

    task automatic wait_tx_count(input int target, input string what);
        int t;
        t = 0;
        while (tx_log.size() < target) begin
            @(negedge clk);
            t++;
            if (t > 20000) fail_timeout(what);
        end
    endtask

    function automatic logic [31:0] reg_value(input int addr);
        return (addr * 32'h0101_0101) ^ 32'hA5A5_A5A5;
    endfunction

    // UART transmitter, done after 2 to 9 cycles
    initial begin : tx_model
        logic [31:0] d;
        i_tx_done = 1'b0;
        forever begin
            @(negedge clk);
            if (o_tx_start) begin
                tx_log.push_back(o_tx_data);
                d = draw_bits(3);
                repeat (d + 2) @(negedge clk);
                i_tx_done = 1'b1;
                @(negedge clk);
                i_tx_done = 1'b0;
            end
        end
    end

    // CPU and register file models
    initial begin : cpu_model
        logic rd_pending;
        int   rd_addr;
        rd_pending     = 1'b0;
        rd_addr        = 0;
        i_pc           = 32'h0000_1000;
        i_regfile_data = '0;
        forever begin
            @(negedge clk);
            init_done = 1'b1;
            if (o_cpu_en) i_pc = i_pc + 4;
            if (prev_en && !o_cpu_en && run_mode) push_word(i_pc);  // PC when RUN ended
            prev_en = o_cpu_en;
            if (rd_pending) i_regfile_data = reg_value(rd_addr);  // Cycle after the read
            rd_pending = o_regfile_rd;
            rd_addr    = int'(o_regfile_raddr);
        end
    end

    always @(posedge clk) if (o_tx_start) exp_rd <= exp_rd + 1;

    always @(posedge clk) if (o_imem_wen) imem_wr_cnt <= imem_wr_cnt + 1;

    a_reset_quiet: assert property (@(posedge clk) (init_done && !started) |->
        !(o_cpu_en || o_tx_start || o_imem_wen || o_regfile_rd))
        else report_error("output active before the first command");

    a_tx_byte: assert property (@(posedge clk) o_tx_start |->
        (exp_rd < exp_wr) && (o_tx_data == exp_bytes[exp_rd]))
        else report_error($sformatf("unexpected transmit byte %h", o_tx_data));

    a_imem_write: assert property (@(posedge clk) o_imem_wen |->
        (imem_wr_cnt < n_words) && (o_imem_waddr == imem_wr_cnt)
        && (o_imem_data == exp_word[imem_wr_cnt]) && (o_imem_wsize == WSIZE_WORD))
        else report_error($sformatf("bad IMEM write %h at %0d", o_imem_data, o_imem_waddr));

    a_step_width: assert property (@(posedge clk) disable iff (i_rst)
        (!run_mode && $rose(o_cpu_en)) |=> !o_cpu_en)
        else report_error("STEP enable longer than one cycle");

    a_run_hold: assert property (@(posedge clk) disable iff (i_rst)
        (run_mode && o_cpu_en && !halt_pop) |=> o_cpu_en)
        else report_error("CPU enable dropped during RUN");

    a_run_stop: assert property (@(posedge clk) disable iff (i_rst)
        (run_mode && $fell(o_cpu_en)) |-> $past(halt_pop))
        else report_error("CPU enable fell without a HALT pop");

    initial begin : stimulus
        i_rst     = 1'b1;
        i_rx_data = '0;
        i_rx_done = 1'b0;
        repeat (16) @(negedge clk);
        i_rst = 1'b0;
        repeat (8) @(negedge clk);
        started = 1'b1;

        // LOAD of eight words
        for (int i = 0; i < 8; i++) exp_word[i] = draw_bits(32);
        n_words = 8;
        push_byte(REPLY_ACK);
        send_byte(CMD_LOAD);
        send_byte(8'd8);
        for (int i = 0; i < 32; i++) send_byte(exp_word[i / 4][8*(i % 4) +: 8]);
        wait_tx_count(1, "the LOAD acknowledge");
        a_all_words: assert (imem_wr_cnt == n_words)
            else report_error($sformatf("%0d IMEM writes for %0d words",
                                        imem_wr_cnt, n_words));

        push_word(i_pc + 4);
        send_byte(CMD_STEP);
        wait_tx_count(5, "the STEP PC reply");

        run_mode = 1'b1;
        send_byte(CMD_RUN);
        repeat (25) @(negedge clk);
        send_byte(CMD_HALT);
        wait_tx_count(9, "the PC reply after HALT");
        run_mode = 1'b0;

        for (int r = 0; r < N_REGS; r++) push_word(reg_value(r));
        send_byte(CMD_REGS);
        wait_tx_count(137, "the register dump");

        // Back to back commands while busy
        push_word(i_pc + 4);
        push_byte(REPLY_NAK);
        push_byte(REPLY_NAK);
        for (int r = 0; r < N_REGS; r++) push_word(reg_value(r));
        send_byte(CMD_STEP);
        send_byte(8'h7A);
        send_byte(CMD_HALT);
        send_byte(CMD_REGS);
        wait_tx_count(271, "the queued command replies");

        repeat (40) @(negedge clk);  // Any extra byte would trip a_tx_byte
        if (tx_log.size() == exp_wr && exp_rd == exp_wr) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_error($sformatf("byte count mismatch, sent %0d expected %0d",
                                   tx_log.size(), exp_wr));
        end
    end

endmodule

/* rtl/du_subsystem_top.sv */
`timescale 1ns/1ns
// Debug subsystem top
// Receive byte FIFO feeding the debug unit
module du_subsystem_top (
    input  logic [du_cmd_pkg::NB_UART_DATA-1:0]    i_rx_data,
    input  logic                                   i_rx_done,
    output logic                                   o_rx_full,
    output logic                                   o_tx_start,
    output logic [du_cmd_pkg::NB_UART_DATA-1:0]    o_tx_data,
    input  logic                                   i_tx_done,
    output logic                                   o_cpu_en,
    input  logic [du_cpu_pkg::NB_PC-1:0]           i_pc,
    output logic                                   o_regfile_rd,
    output logic [du_cpu_pkg::NB_REGFILE_ADDR-1:0] o_regfile_raddr,
    input  logic [du_cpu_pkg::NB_REG-1:0]          i_regfile_data,
    output logic [du_cpu_pkg::NB_INSTRUCTION-1:0]  o_imem_data,
    output logic [du_cpu_pkg::IMEM_ADDR_WIDTH-1:0] o_imem_waddr,
    output logic [du_cpu_pkg::NB_WSIZE-1:0]        o_imem_wsize,
    output logic                                   o_imem_wen,
    input  logic                                   i_rst,
    input  logic                                   clk
);
    import du_cmd_pkg::*;

    logic [NB_UART_DATA-1:0] rx_head;  // FIFO head byte
    logic                    rx_empty;
    logic                    rx_rd;

    du_byte_fifo #(
        .DEPTH (16)
    ) u_rx_fifo (
        .i_wr    (i_rx_done),
        .i_wdata (i_rx_data),
        .i_rd    (rx_rd),
        .o_rdata (rx_head),
        .o_empty (rx_empty),
        .o_full  (o_rx_full),
        .i_rst   (i_rst),
        .clk     (clk)
    );

    debug_unit_top u_debug_unit (
        .o_cpu_en        (o_cpu_en),
        .o_tx_start      (o_tx_start),
        .o_tx_data       (o_tx_data),
        .o_rd            (rx_rd),
        .o_imem_data     (o_imem_data),
        .o_imem_waddr    (o_imem_waddr),
        .o_imem_wsize    (o_imem_wsize),
        .o_imem_wen      (o_imem_wen),
        .o_regfile_rd    (o_regfile_rd),
        .o_regfile_raddr (o_regfile_raddr),
        .i_pc            (i_pc),
        .i_regfile_data  (i_regfile_data),
        .i_rx_data       (rx_head),
        .i_rx_avail      (!rx_empty),
        .i_tx_done       (i_tx_done),
        .i_rst           (i_rst),
        .clk             (clk)
    );

endmodule

/* debug_unit/debug_unit_top.sv */
`timescale 1ns/1ns
// Debug unit top
// Master, IMEM loader and register sender with ORed UART outputs
module debug_unit_top (
    output logic                                   o_cpu_en,
    output logic                                   o_tx_start,
    output logic [du_cmd_pkg::NB_UART_DATA-1:0]    o_tx_data,
    output logic                                   o_rd,
    output logic [du_cpu_pkg::NB_INSTRUCTION-1:0]  o_imem_data,
    output logic [du_cpu_pkg::IMEM_ADDR_WIDTH-1:0] o_imem_waddr,
    output logic [du_cpu_pkg::NB_WSIZE-1:0]        o_imem_wsize,
    output logic                                   o_imem_wen,
    output logic                                   o_regfile_rd,
    output logic [du_cpu_pkg::NB_REGFILE_ADDR-1:0] o_regfile_raddr,
    input  logic [du_cpu_pkg::NB_PC-1:0]           i_pc,
    input  logic [du_cpu_pkg::NB_REG-1:0]          i_regfile_data,
    input  logic [du_cmd_pkg::NB_UART_DATA-1:0]    i_rx_data,
    input  logic                                   i_rx_avail,
    input  logic                                   i_tx_done,
    input  logic                                   i_rst,
    input  logic                                   clk
);
    import du_cmd_pkg::*;

    logic                    load_start;
    logic                    regs_start;
    logic                    loader_done;
    logic                    regs_done;
    logic                    master_tx_start;
    logic                    loader_tx_start;
    logic                    regs_tx_start;
    logic [NB_UART_DATA-1:0] master_tx_data;
    logic [NB_UART_DATA-1:0] loader_tx_data;
    logic [NB_UART_DATA-1:0] regs_tx_data;
    logic                    master_rd;
    logic                    loader_rd;

    // Idle blocks hold zero, so OR merges the owner's signals
    assign o_tx_start = master_tx_start | loader_tx_start | regs_tx_start;
    assign o_tx_data  = master_tx_data | loader_tx_data | regs_tx_data;
    assign o_rd       = master_rd | loader_rd;

    du_master u_du_master (
        .o_cpu_en          (o_cpu_en),
        .o_load_start      (load_start),
        .o_send_regs_start (regs_start),
        .o_tx_start        (master_tx_start),
        .o_tx_data         (master_tx_data),
        .o_rd              (master_rd),
        .i_loader_done     (loader_done),
        .i_send_regs_done  (regs_done),
        .i_pc              (i_pc),
        .i_rx_data         (i_rx_data),
        .i_rx_avail        (i_rx_avail),
        .i_tx_done         (i_tx_done),
        .i_rst             (i_rst),
        .clk               (clk)
    );

    du_imem_loader u_du_imem_loader (
        .o_done       (loader_done),
        .o_tx_start   (loader_tx_start),
        .o_tx_data    (loader_tx_data),
        .o_rd         (loader_rd),
        .o_imem_data  (o_imem_data),
        .o_imem_waddr (o_imem_waddr),
        .o_imem_wsize (o_imem_wsize),
        .o_imem_wen   (o_imem_wen),
        .i_start      (load_start),
        .i_rx_data    (i_rx_data),
        .i_rx_avail   (i_rx_avail),
        .i_tx_done    (i_tx_done),
        .i_rst        (i_rst),
        .clk          (clk)
    );

    du_regfile_tx u_du_regfile_tx (
        .o_done          (regs_done),
        .o_tx_start      (regs_tx_start),
        .o_tx_data       (regs_tx_data),
        .o_regfile_rd    (o_regfile_rd),
        .o_regfile_raddr (o_regfile_raddr),
        .i_start         (regs_start),
        .i_regfile_data  (i_regfile_data),
        .i_tx_done       (i_tx_done),
        .i_rst           (i_rst),
        .clk             (clk)
    );

    a_single_tx_owner: assert property (@(posedge clk) disable iff (i_rst)
        $onehot0({master_tx_start, loader_tx_start, regs_tx_start}))
        else $error("More than one debug block started a UART byte");

endmodule

/* debug_unit/du_regfile_tx.sv */
`timescale 1ns/1ns
// Register file sender
// Reads registers 0 to 31 and sends each as four bytes, LSB first
module du_regfile_tx (
    output logic                                   o_done,
    output logic                                   o_tx_start,
    output logic [du_cmd_pkg::NB_UART_DATA-1:0]    o_tx_data,
    output logic                                   o_regfile_rd,
    output logic [du_cpu_pkg::NB_REGFILE_ADDR-1:0] o_regfile_raddr,
    input  logic                                   i_start,
    input  logic [du_cpu_pkg::NB_REG-1:0]          i_regfile_data,
    input  logic                                   i_tx_done,
    input  logic                                   i_rst,
    input  logic                                   clk
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_WAIT_DATA, ST_CAPTURE, ST_SEND, ST_WAIT_TX
    } regtx_state_e;

    regtx_state_e           state;
    logic [NB_REG-1:0]      word_q;
    logic [NB_BYTE_SEL-1:0] byte_cnt;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state           <= ST_IDLE;
            o_done          <= 1'b0;
            o_tx_start      <= 1'b0;
            o_tx_data       <= '0;
            o_regfile_rd    <= 1'b0;
            o_regfile_raddr <= '0;
            byte_cnt        <= '0;
        end else begin
            o_done       <= 1'b0;
            o_tx_start   <= 1'b0;
            o_regfile_rd <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        o_regfile_rd    <= 1'b1;
                        o_regfile_raddr <= '0;
                        state           <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA: state <= ST_CAPTURE;  // Read port answers a cycle later
                ST_CAPTURE: begin
                    word_q   <= i_regfile_data;
                    byte_cnt <= '0;
                    state    <= ST_SEND;
                end
                ST_SEND: begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= word_q[NB_UART_DATA-1:0];
                    word_q     <= word_q >> NB_UART_DATA;
                    state      <= ST_WAIT_TX;
                end
                ST_WAIT_TX: begin
                    if (i_tx_done) begin
                        o_tx_data <= '0;
                        if (byte_cnt != NB_BYTE_SEL'(BYTES_PER_WORD - 1)) begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= ST_SEND;
                        end else if (o_regfile_raddr == NB_REGFILE_ADDR'(N_REGS - 1)) begin
                            o_done <= 1'b1;  // Whole file sent
                            state  <= ST_IDLE;
                        end else begin
                            o_regfile_rd    <= 1'b1;
                            o_regfile_raddr <= o_regfile_raddr + 1'b1;
                            state           <= ST_WAIT_DATA;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* debug_unit/du_imem_loader.sv */
`timescale 1ns/1ns
// Instruction memory loader
// Count byte, then little-endian words written from address 0, then ACK
module du_imem_loader (
    output logic                                      o_done,
    output logic                                      o_tx_start,
    output logic [du_cmd_pkg::NB_UART_DATA-1:0]       o_tx_data,
    output logic                                      o_rd,
    output logic [du_cpu_pkg::NB_INSTRUCTION-1:0]     o_imem_data,
    output logic [du_cpu_pkg::IMEM_ADDR_WIDTH-1:0]    o_imem_waddr,
    output logic [du_cpu_pkg::NB_WSIZE-1:0]           o_imem_wsize,
    output logic                                      o_imem_wen,
    input  logic                                      i_start,
    input  logic [du_cmd_pkg::NB_UART_DATA-1:0]       i_rx_data,
    input  logic                                      i_rx_avail,
    input  logic                                      i_tx_done,
    input  logic                                      i_rst,
    input  logic                                      clk
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_COUNT, ST_DATA, ST_ACK, ST_WAIT_TX
    } loader_state_e;

    loader_state_e           state;
    logic [NB_UART_DATA-1:0] words_left;
    logic [NB_BYTE_SEL-1:0]  byte_cnt;

    assign o_imem_wsize = o_imem_wen ? WSIZE_WORD : '0;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state        <= ST_IDLE;
            o_done       <= 1'b0;
            o_tx_start   <= 1'b0;
            o_tx_data    <= '0;
            o_rd         <= 1'b0;
            o_imem_wen   <= 1'b0;
            o_imem_waddr <= '0;
            byte_cnt     <= '0;
        end else begin
            o_done     <= 1'b0;
            o_tx_start <= 1'b0;
            o_rd       <= 1'b0;
            o_imem_wen <= 1'b0;
            if (o_imem_wen) o_imem_waddr <= o_imem_waddr + 1'b1;  // Next word slot
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        o_imem_waddr <= '0;
                        byte_cnt     <= '0;
                        state        <= ST_COUNT;
                    end
                end
                ST_COUNT: begin
                    // !o_rd skips the cycle in which the popped byte is still at the head
                    if (i_rx_avail && !o_rd) begin
                        o_rd       <= 1'b1;
                        words_left <= i_rx_data;
                        state      <= (i_rx_data == '0) ? ST_ACK : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (i_rx_avail && !o_rd) begin
                        o_rd        <= 1'b1;
                        o_imem_data <= {i_rx_data, o_imem_data[NB_INSTRUCTION-1:NB_UART_DATA]};
                        byte_cnt    <= byte_cnt + 1'b1;  // Wraps after the last byte
                        if (byte_cnt == NB_BYTE_SEL'(BYTES_PER_WORD - 1)) begin
                            o_imem_wen <= 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == NB_UART_DATA'(1)) state <= ST_ACK;
                        end
                    end
                end
                ST_ACK: begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= REPLY_ACK;
                    state      <= ST_WAIT_TX;
                end
                ST_WAIT_TX: begin
                    if (i_tx_done) begin
                        o_tx_data <= '0;
                        o_done    <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* debug_unit/du_master.sv */
`timescale 1ns/1ns
// Debug unit master
// Command decoder, CPU enable control, PC and NAK replies
module du_master (
    output logic                                o_cpu_en,
    output logic                                o_load_start,
    output logic                                o_send_regs_start,
    output logic                                o_tx_start,
    output logic [du_cmd_pkg::NB_UART_DATA-1:0] o_tx_data,
    output logic                                o_rd,
    input  logic                                i_loader_done,
    input  logic                                i_send_regs_done,
    input  logic [du_cpu_pkg::NB_PC-1:0]        i_pc,
    input  logic [du_cmd_pkg::NB_UART_DATA-1:0] i_rx_data,
    input  logic                                i_rx_avail,
    input  logic                                i_tx_done,
    input  logic                                i_rst,
    input  logic                                clk
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_DECODE, ST_WAIT_SUB, ST_STEP,
        ST_RUN, ST_SAMPLE, ST_SEND, ST_WAIT_TX
    } master_state_e;

    master_state_e          state;
    du_cmd_e                cmd_q;
    logic [NB_PC-1:0]       reply_q;   // Shifted out LSB first
    logic [NB_BYTE_SEL-1:0] byte_cnt;
    logic                   tx_busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state             <= ST_IDLE;
            o_cpu_en          <= 1'b0;
            o_load_start      <= 1'b0;
            o_send_regs_start <= 1'b0;
            o_tx_start        <= 1'b0;
            o_tx_data         <= '0;
            o_rd              <= 1'b0;
            byte_cnt          <= '0;
        end else begin
            o_rd              <= 1'b0;  // Strobes last a single cycle
            o_tx_start        <= 1'b0;
            o_load_start      <= 1'b0;
            o_send_regs_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_rx_avail) begin
                        o_rd  <= 1'b1;
                        cmd_q <= du_cmd_e'(i_rx_data);
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    case (cmd_q)
                        CMD_LOAD: begin
                            o_load_start <= 1'b1;
                            state        <= ST_WAIT_SUB;
                        end
                        CMD_REGS: begin
                            o_send_regs_start <= 1'b1;
                            state             <= ST_WAIT_SUB;
                        end
                        CMD_STEP: begin
                            o_cpu_en <= 1'b1;
                            state    <= ST_STEP;
                        end
                        CMD_RUN: begin
                            o_cpu_en <= 1'b1;
                            state    <= ST_RUN;
                        end
                        default: begin  // HALT while stopped, or unknown byte
                            reply_q  <= NB_PC'(REPLY_NAK);
                            byte_cnt <= NB_BYTE_SEL'(BYTES_PER_WORD - 1);  // Single byte
                            state    <= ST_SEND;
                        end
                    endcase
                end
                ST_WAIT_SUB: if (i_loader_done || i_send_regs_done) state <= ST_IDLE;
                ST_STEP: begin
                    o_cpu_en <= 1'b0;  // Last enabled cycle of STEP or RUN
                    state    <= ST_SAMPLE;
                end
                ST_RUN: begin
                    // Only HALT matters while running, other bytes are dropped
                    if (i_rx_avail && !o_rd) begin
                        o_rd <= 1'b1;
                        if (i_rx_data == CMD_HALT) state <= ST_STEP;  // Enable drops after the pop
                    end
                end
                ST_SAMPLE: begin
                    reply_q  <= i_pc;  // PC has settled after the last enable
                    byte_cnt <= '0;
                    state    <= ST_SEND;
                end
                ST_SEND: begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= reply_q[NB_UART_DATA-1:0];
                    reply_q    <= reply_q >> NB_UART_DATA;
                    state      <= ST_WAIT_TX;
                end
                ST_WAIT_TX: begin
                    if (i_tx_done) begin
                        o_tx_data <= '0;
                        if (byte_cnt == NB_BYTE_SEL'(BYTES_PER_WORD - 1)) begin
                            state <= ST_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= ST_SEND;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Tracks a byte handed to the UART but not yet finished
    always_ff @(posedge clk) begin
        if (i_rst) tx_busy <= 1'b0;
        else if (o_tx_start) tx_busy <= 1'b1;
        else if (i_tx_done) tx_busy <= 1'b0;
    end

    a_no_start_in_flight: assert property (@(posedge clk) disable iff (i_rst)
        o_tx_start |-> !tx_busy)
        else $error("Master started a byte while the previous one was in flight");

endmodule

/* rtl/du_byte_fifo.sv */
`timescale 1ns/1ns
// Show-ahead receive byte FIFO
// Circular buffer, head byte always on o_rdata
module du_byte_fifo #(
    parameter int DEPTH = 16  // Power of two
) (
    input  logic                                i_wr,
    input  logic [du_cmd_pkg::NB_UART_DATA-1:0] i_wdata,
    input  logic                                i_rd,
    output logic [du_cmd_pkg::NB_UART_DATA-1:0] o_rdata,
    output logic                                o_empty,
    output logic                                o_full,
    input  logic                                i_rst,
    input  logic                                clk
);
    import du_cmd_pkg::*;

    logic [NB_UART_DATA-1:0]  mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;  // One extra bit to tell full from empty
    logic                     do_wr;
    logic                     do_rd;

    assign do_wr   = i_wr && !o_full;  // Byte dropped when full
    assign do_rd   = i_rd && !o_empty;
    assign o_rdata = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH);

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= i_wdata;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_rd_when_empty: assert property (@(posedge clk) disable iff (i_rst)
        i_rd |-> !o_empty)
        else $error("Receive FIFO popped while empty");

endmodule

/* common/du_cpu_pkg.sv */
// CPU-side sizes seen by the debug unit
// PC, register, instruction, IMEM address and write size code
package du_cpu_pkg;

    localparam int NB_PC           = 32;
    localparam int NB_REG          = 32;
    localparam int NB_INSTRUCTION  = 32;
    localparam int IMEM_ADDR_WIDTH = 8;   // Word addressed
    localparam int NB_REGFILE_ADDR = 5;
    localparam int N_REGS          = 32;

    localparam int                  NB_WSIZE   = 2;
    localparam logic [NB_WSIZE-1:0] WSIZE_WORD = 2'b10;

    localparam int BYTES_PER_WORD = 4;
    localparam int NB_BYTE_SEL    = $clog2(BYTES_PER_WORD);  // Byte index within a word

endpackage

/* common/du_cmd_pkg.sv */
// Debug link definitions
// UART byte width, command opcodes and reply codes
package du_cmd_pkg;

    localparam int NB_UART_DATA = 8;  // One UART frame

    // Command opcodes are plain ASCII letters
    typedef enum logic [NB_UART_DATA-1:0] {
        CMD_LOAD = 8'h4C,  // 'L'
        CMD_STEP = 8'h53,  // 'S'
        CMD_RUN  = 8'h52,  // 'R'
        CMD_HALT = 8'h48,  // 'H'
        CMD_REGS = 8'h47   // 'G'
    } du_cmd_e;

    localparam logic [NB_UART_DATA-1:0] REPLY_ACK = 8'h06;
    localparam logic [NB_UART_DATA-1:0] REPLY_NAK = 8'h15;

endpackage
